//--- dual_issue_top.f
+incdir+src
src/isa_pkg.sv
src/pipe_pkg.sv
src/issue_if.sv
src/inst_decoder.sv
src/pair_issue.sv
src/credit_fifo.sv
src/alu_execute.sv
src/reg_writeback.sv
src/dual_issue_top.sv
tb/dual_issue_chk.sv
tb/dual_issue_tb.sv

//--- tb/dual_issue_tb.sv
`timescale 1ns/100ps
`include "dual_issue_cfg.svh"

module dual_issue_tb;

typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  dest;
    logic [31:0] value;
    logic        exc;
} expect_t;

localparam logic [31:0] PC_BASE = 32'h1c00_0000;

logic        clk;
logic        rst;
logic        res_stall;
logic        a_valid;
logic [31:0] a_pc;
logic [31:0] a_inst;
logic        b_valid;
logic [31:0] b_pc;
logic [31:0] b_inst;
logic [1:0]  consume;
logic        res_a_valid;
logic [31:0] res_a_pc;
logic [4:0]  res_a_dest;
logic [31:0] res_a_value;
logic        res_a_exc;
logic        res_b_valid;
logic [31:0] res_b_pc;
logic [4:0]  res_b_dest;
logic [31:0] res_b_value;
logic        res_b_exc;

logic [31:0] prog [$];
int          test_first [$];
string       test_name [$];
bit          test_stall [$];
expect_t     exp_q [$];
logic [31:0] model_rf [32];
string       cur_test;
int          errors;
int          checks;
int          cycles;
int          cycle_limit;
int          q_count;           // Issue queue entries, one credit each.

dual_issue_top dut0 (
    .clk(clk),
    .rst(rst),
    .res_stall(res_stall),
    .a_valid(a_valid),
    .a_pc(a_pc),
    .a_inst(a_inst),
    .b_valid(b_valid),
    .b_pc(b_pc),
    .b_inst(b_inst),
    .consume(consume),
    .res_a_valid(res_a_valid),
    .res_a_pc(res_a_pc),
    .res_a_dest(res_a_dest),
    .res_a_value(res_a_value),
    .res_a_exc(res_a_exc),
    .res_b_valid(res_b_valid),
    .res_b_pc(res_b_pc),
    .res_b_dest(res_b_dest),
    .res_b_value(res_b_value),
    .res_b_exc(res_b_exc)
);

initial begin
    clk = 1'b0;
    forever begin
        #4 clk = ~clk;
    end
end

function automatic logic [31:0] pc_of(input int idx);
    return PC_BASE + 32'(4 * idx);
endfunction

function automatic logic [31:0] enc_3r(input logic [16:0] op, input int rd, input int rj,
                                       input int rk);
    return {op, rk[4:0], rj[4:0], rd[4:0]};
endfunction

function automatic logic [31:0] enc_2ri(input logic [9:0] op, input int rd, input int rj,
                                        input logic [11:0] imm);
    return {op, imm, rj[4:0], rd[4:0]};
endfunction

// 0 unknown, 1 three-register, 2 register plus immediate.
function automatic int op_class(input logic [31:0] w);
    case (w[31:15])
        isa_pkg::OP3R_ADD_W, isa_pkg::OP3R_SUB_W, isa_pkg::OP3R_AND,
        isa_pkg::OP3R_OR, isa_pkg::OP3R_XOR: return 1;
        default: begin
            if (w[31:22] == isa_pkg::OP2RI12_ADDI_W || w[31:22] == isa_pkg::OP2RI12_ORI) begin
                return 2;
            end
            return 0;
        end
    endcase
endfunction

// Executes one word in program order against the model register file.
function automatic expect_t execute_ref(input logic [31:0] pc, input logic [31:0] w);
    expect_t     e;
    logic [31:0] x;
    logic [31:0] y;
    x       = model_rf[w[9:5]];
    y       = model_rf[w[14:10]];
    e.pc    = pc;
    e.dest  = w[4:0];
    e.exc   = 1'b0;
    e.value = 32'd0;
    case (w[31:15])
        isa_pkg::OP3R_ADD_W: e.value = x + y;
        isa_pkg::OP3R_SUB_W: e.value = x - y;
        isa_pkg::OP3R_AND:   e.value = x & y;
        isa_pkg::OP3R_OR:    e.value = x | y;
        isa_pkg::OP3R_XOR:   e.value = x ^ y;
        default: begin
            if (w[31:22] == isa_pkg::OP2RI12_ADDI_W) begin
                e.value = x + {{20{w[21]}}, w[21:10]};
            end else if (w[31:22] == isa_pkg::OP2RI12_ORI) begin
                e.value = x | {20'd0, w[21:10]};
            end else begin
                e.exc  = 1'b1;
                e.dest = 5'd0;
            end
        end
    endcase
    if (!e.exc && e.dest != 5'd0) begin
        model_rf[e.dest] = e.value;
    end
    return e;
endfunction

function automatic logic can_pair(input logic [31:0] wa, input logic [31:0] wb);
    logic [4:0] src1;
    logic [4:0] src2;
    src1 = (op_class(wb) != 0) ? wb[9:5] : 5'd0;
    src2 = (op_class(wb) == 1) ? wb[14:10] : 5'd0;
    return op_class(wa) != 0 && (wa[4:0] == 5'd0 || (wa[4:0] != src1 && wa[4:0] != src2));
endfunction

task automatic check_val(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("error: %s expected %h actual %h", name, expected, actual);
    end
endtask

task automatic compare_result(input string lane, input logic [31:0] pc, input logic [4:0] dest,
                              input logic [31:0] value, input logic exc);
    expect_t e;
    if (exp_q.size() == 0) begin
        errors++;
        $display("%s: lane %s gave a result at pc %h with nothing outstanding",
                 cur_test, lane, pc);
    end else begin
        e = exp_q.pop_front();
        check_val({cur_test, " lane ", lane, " pc"}, e.pc, pc);
        check_val({cur_test, " lane ", lane, " dest"}, 32'(e.dest), 32'(dest));
        check_val({cur_test, " lane ", lane, " value"}, e.value, value);
        check_val({cur_test, " lane ", lane, " exception"}, 32'(e.exc), 32'(exc));
    end
endtask

task automatic add_test(input string name, input bit stall);
    test_first.push_back(prog.size());
    test_name.push_back(name);
    test_stall.push_back(stall);
endtask

task automatic add_random(input int n);
    int          kind;
    int          rd;
    int          rj;
    int          rk;
    logic [11:0] imm;
    repeat (n) begin
        kind = $urandom % 8;
        rd   = $urandom % 8;            // Small register range makes hazards common.
        rj   = $urandom % 8;
        rk   = $urandom % 8;
        imm  = 12'($urandom);
        case (kind)
            0: prog.push_back(enc_3r(isa_pkg::OP3R_ADD_W, rd, rj, rk));
            1: prog.push_back(enc_3r(isa_pkg::OP3R_SUB_W, rd, rj, rk));
            2: prog.push_back(enc_3r(isa_pkg::OP3R_AND, rd, rj, rk));
            3: prog.push_back(enc_3r(isa_pkg::OP3R_OR, rd, rj, rk));
            4: prog.push_back(enc_3r(isa_pkg::OP3R_XOR, rd, rj, rk));
            5: prog.push_back(enc_2ri(isa_pkg::OP2RI12_ADDI_W, rd, rj, imm));
            6: prog.push_back(enc_2ri(isa_pkg::OP2RI12_ORI, rd, rj, imm));
            default: prog.push_back(32'h0000_0000);
        endcase
    end
endtask

task automatic run_test(input int t);
    int         idx;
    int         last;
    int         iter;
    int         errs_before;
    logic [1:0] want;
    cur_test    = test_name[t];
    idx         = test_first[t];
    last        = test_first[t + 1];
    iter        = 0;
    errs_before = errors;
    for (int i = idx; i < last; i++) begin
        exp_q.push_back(execute_ref(pc_of(i), prog[i]));
    end
    while (idx < last) begin
        @(negedge clk);
        res_stall = test_stall[t] && ((iter >= 8 && iter < 28) || $urandom % 3 == 0);
        a_valid   = 1'b1;
        a_pc      = pc_of(idx);
        a_inst    = prog[idx];
        b_valid   = idx + 1 < last;
        b_pc      = pc_of(idx + 1);
        b_inst    = b_valid ? prog[idx + 1] : 32'd0;
        @(posedge clk);
        if (res_stall || q_count == `DI_QUEUE_DEPTH) begin
            want = 2'd0;                // Held, or no credit left.
        end else if (b_valid && can_pair(a_inst, b_inst)) begin
            want = 2'd2;
        end else begin
            want = 2'd1;
        end
        check_val({cur_test, " consume"}, 32'(want), 32'(consume));
        idx  = idx + consume;
        iter = iter + 1;
    end
    @(negedge clk);
    a_valid   = 1'b0;
    b_valid   = 1'b0;
    res_stall = 1'b0;
    while (exp_q.size() != 0) begin
        @(negedge clk);
    end
    $display("test %-14s %3d instructions, %0d errors", cur_test, last - test_first[t],
             errors - errs_before);
endtask

// Queue pops whenever it holds an entry and results are not stalled.
always @(posedge clk) begin
    if (rst) begin
        q_count <= 0;
    end else begin
        q_count <= q_count + (consume != 2'd0) - (q_count != 0 && !res_stall);
    end
end

// Lane a is older than lane b.
always @(posedge clk) begin
    if (!rst) begin
        if (res_a_valid) begin
            compare_result("a", res_a_pc, res_a_dest, res_a_value, res_a_exc);
        end
        if (res_b_valid) begin
            compare_result("b", res_b_pc, res_b_dest, res_b_value, res_b_exc);
        end
    end
end

always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
        $display("Timeout after %0d cycles with %0d results outstanding", cycles, exp_q.size());
        $display("Simulation finished: FAIL");
        $finish;
    end
end

initial begin
    int asserts;
    void'($urandom(9));
    rst       = 1'b1;
    res_stall = 1'b0;
    a_valid   = 1'b0;
    a_pc      = 32'd0;
    a_inst    = 32'd0;
    b_valid   = 1'b0;
    b_pc      = 32'd0;
    b_inst    = 32'd0;
    errors    = 0;
    checks    = 0;
    cycles    = 0;
    foreach (model_rf[i]) begin
        model_rf[i] = 32'd0;
    end

    add_test("alu_ops", 1'b0);
    prog.push_back(enc_2ri(isa_pkg::OP2RI12_ADDI_W, 1, 0, 12'h123));
    prog.push_back(enc_2ri(isa_pkg::OP2RI12_ADDI_W, 2, 0, 12'hffb));  // Negative immediate.
    prog.push_back(enc_2ri(isa_pkg::OP2RI12_ORI, 3, 0, 12'h8f0));     // Top bit not extended.
    prog.push_back(enc_2ri(isa_pkg::OP2RI12_ORI, 4, 2, 12'hfff));
    prog.push_back(enc_3r(isa_pkg::OP3R_ADD_W, 5, 1, 2));
    prog.push_back(enc_3r(isa_pkg::OP3R_SUB_W, 6, 1, 2));
    prog.push_back(enc_3r(isa_pkg::OP3R_AND, 7, 3, 2));
    prog.push_back(enc_3r(isa_pkg::OP3R_OR, 8, 1, 3));
    prog.push_back(enc_3r(isa_pkg::OP3R_XOR, 9, 4, 1));
    prog.push_back(enc_2ri(isa_pkg::OP2RI12_ADDI_W, 10, 3, 12'h800));
    prog.push_back(enc_3r(isa_pkg::OP3R_SUB_W, 11, 0, 1));
    prog.push_back(enc_3r(isa_pkg::OP3R_ADD_W, 12, 5, 6));

    add_test("pairing", 1'b0);
    prog.push_back(enc_3r(isa_pkg::OP3R_ADD_W, 13, 1, 3));
    prog.push_back(enc_3r(isa_pkg::OP3R_XOR, 14, 2, 4));
    prog.push_back(enc_2ri(isa_pkg::OP2RI12_ADDI_W, 17, 1, 12'h001));
    prog.push_back(enc_3r(isa_pkg::OP3R_ADD_W, 18, 17, 17));
    prog.push_back(enc_3r(isa_pkg::OP3R_SUB_W, 19, 2, 1));
    prog.push_back(enc_3r(isa_pkg::OP3R_ADD_W, 0, 1, 2));             // Dest zero.
    prog.push_back(enc_3r(isa_pkg::OP3R_SUB_W, 20, 0, 0));
    prog.push_back(enc_3r(isa_pkg::OP3R_SUB_W, 22, 3, 4));
    prog.push_back(enc_3r(isa_pkg::OP3R_XOR, 23, 1, 22));
    prog.push_back(enc_2ri(isa_pkg::OP2RI12_ORI, 24, 23, 12'h055));
    prog.push_back(enc_3r(isa_pkg::OP3R_OR, 25, 24, 13));

    add_test("back_to_back", 1'b0);
    prog.push_back(enc_2ri(isa_pkg::OP2RI12_ADDI_W, 26, 0, 12'h007));
    prog.push_back(enc_3r(isa_pkg::OP3R_ADD_W, 26, 26, 26));
    prog.push_back(enc_3r(isa_pkg::OP3R_SUB_W, 27, 26, 1));
    prog.push_back(enc_3r(isa_pkg::OP3R_XOR, 28, 27, 26));
    prog.push_back(enc_3r(isa_pkg::OP3R_OR, 29, 28, 27));
    prog.push_back(enc_3r(isa_pkg::OP3R_AND, 30, 29, 28));
    prog.push_back(enc_2ri(isa_pkg::OP2RI12_ADDI_W, 31, 30, 12'hfff));
    prog.push_back(enc_3r(isa_pkg::OP3R_ADD_W, 26, 31, 30));
    prog.push_back(enc_3r(isa_pkg::OP3R_SUB_W, 26, 26, 31));
    prog.push_back(enc_2ri(isa_pkg::OP2RI12_ORI, 27, 26, 12'h0f0));

    add_test("exceptions", 1'b0);
    prog.push_back(32'h0000_0000);                                     // Unknown in slot a.
    prog.push_back(enc_3r(isa_pkg::OP3R_ADD_W, 1, 1, 1));
    prog.push_back(enc_3r(isa_pkg::OP3R_ADD_W, 5, 1, 2));
    prog.push_back(32'hffff_8000);
    prog.push_back(enc_2ri(isa_pkg::OP2RI12_ADDI_W, 6, 5, 12'h010));
    prog.push_back(32'h0012_8000);                                     // Unused 3R code.
    prog.push_back(enc_3r(isa_pkg::OP3R_SUB_W, 7, 6, 5));
    prog.push_back(enc_2ri(isa_pkg::OP2RI12_ORI, 8, 7, 12'h7ff));

    add_test("backpressure", 1'b1);
    add_random(48);

    test_first.push_back(prog.size());
    cycle_limit = 4 * prog.size() + 200;

    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int t = 0; t < test_name.size(); t++) begin
        run_test(t);
    end
    repeat (4) @(posedge clk);                                         // Late duplicates.

    asserts = dut0.issue_stage.chk_issue.fails + dut0.issue_queue.chk_fifo.fails;
    $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
             test_name.size(), checks, errors, asserts);
    if (errors == 0 && asserts == 0) begin
        $display("Simulation finished: PASS");
    end else begin
        $display("Simulation finished: FAIL");
    end
    $finish;
end

endmodule

//--- tb/dual_issue_chk.sv
`timescale 1ns/100ps
`include "dual_issue_cfg.svh"

module dual_issue_chk (
    input wire                    clk,
    input wire                    rst,
    input wire                    stall,
    input wire                    push,
    input wire [`DI_CREDIT_W-1:0] occupancy,
    input wire [1:0]              consume
);

bit armed = 1'b0;
int fails = 0;

always @(posedge clk) begin
    armed <= 1'b1;                    // First edge loads the reset state.
end

push_has_room: assert property (@(posedge clk) disable iff (!armed)
    push |-> occupancy < `DI_QUEUE_DEPTH)
else begin
    fails++;
    $error("push with no free queue entry, occupancy %0d", occupancy);
end

occupancy_in_range: assert property (@(posedge clk) disable iff (!armed)
    occupancy <= `DI_QUEUE_DEPTH)
else begin
    fails++;
    $error("queue occupancy %0d above depth", occupancy);
end

idle_when_held: assert property (@(posedge clk) disable iff (!armed)
    (rst || stall) |-> consume == 2'd0)
else begin
    fails++;
    $error("consume %0d during reset or result stall", consume);
end

endmodule

// Entries in flight are the credits spent.
bind pair_issue dual_issue_chk chk_issue (
    .clk(clk),
    .rst(rst),
    .stall(res_stall),
    .push(push),
    .occupancy(FULL_CREDITS - credits),
    .consume(consume)
);

bind credit_fifo dual_issue_chk chk_fifo (
    .clk(clk),
    .rst(rst),
    .stall(stall),
    .push(in_q.push),
    .occupancy(count),
    .consume({1'b0, in_q.push})       // Queue sees each accepted pair as a push.
);

//--- src/dual_issue_top.sv
`timescale 1ns/100ps

module dual_issue_top (
    input  wire         clk,
    input  wire         rst,
    input  wire         res_stall,

    input  wire         a_valid,
    input  wire [31:0]  a_pc,
    input  wire [31:0]  a_inst,
    input  wire         b_valid,
    input  wire [31:0]  b_pc,
    input  wire [31:0]  b_inst,

    output logic [1:0]  consume,

    output logic        res_a_valid,
    output logic [31:0] res_a_pc,
    output logic [4:0]  res_a_dest,
    output logic [31:0] res_a_value,
    output logic        res_a_exc,

    output logic        res_b_valid,
    output logic [31:0] res_b_pc,
    output logic [4:0]  res_b_dest,
    output logic [31:0] res_b_value,
    output logic        res_b_exc
);

pipe_pkg::result_t           ex_a;
pipe_pkg::result_t           ex_b;
pipe_pkg::result_t           wb_a;
pipe_pkg::result_t           wb_b;
logic [pipe_pkg::REG_AW-1:0] rf_raddr [4];
logic [31:0]                 rf_rdata [4];

issue_if #(.item_t(pipe_pkg::issue_pair_t)) iq_in ();
issue_if #(.item_t(pipe_pkg::issue_pair_t)) iq_out ();

pair_issue issue_stage (
    .clk(clk),
    .rst(rst),
    .res_stall(res_stall),
    .a_valid(a_valid),
    .a_pc(a_pc),
    .a_inst(a_inst),
    .b_valid(b_valid),
    .b_pc(b_pc),
    .b_inst(b_inst),
    .consume(consume),
    .iq(iq_in)
);

credit_fifo #(.item_t(pipe_pkg::issue_pair_t)) issue_queue (
    .clk(clk),
    .rst(rst),
    .in_q(iq_in),
    .out_q(iq_out),
    .stall(res_stall)
);

alu_execute execute_stage (
    .clk(clk),
    .rst(rst),
    .stall(res_stall),
    .in_q(iq_out),
    .res_a(ex_a),
    .res_b(ex_b),
    .rf_rdata(rf_rdata),
    .rf_raddr(rf_raddr),
    .wb_a(wb_a),
    .wb_b(wb_b)
);

reg_writeback writeback_stage (
    .clk(clk),
    .rst(rst),
    .stall(res_stall),
    .ex_a(ex_a),
    .ex_b(ex_b),
    .rf_raddr(rf_raddr),
    .rf_rdata(rf_rdata),
    .wb_a(wb_a),
    .wb_b(wb_b)
);

assign res_a_valid = wb_a.valid;
assign res_a_pc    = wb_a.pc;
assign res_a_dest  = wb_a.dest;
assign res_a_value = wb_a.value;
assign res_a_exc   = wb_a.have_exception;

assign res_b_valid = wb_b.valid;
assign res_b_pc    = wb_b.pc;
assign res_b_dest  = wb_b.dest;
assign res_b_value = wb_b.value;
assign res_b_exc   = wb_b.have_exception;

endmodule

//--- src/reg_writeback.sv
`timescale 1ns/100ps
`include "dual_issue_cfg.svh"

module reg_writeback (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         stall,
    input  wire pipe_pkg::result_t      ex_a,
    input  wire pipe_pkg::result_t      ex_b,
    input  wire [pipe_pkg::REG_AW-1:0]  rf_raddr [4],
    output logic [31:0]                 rf_rdata [4],
    output pipe_pkg::result_t           wb_a,
    output pipe_pkg::result_t           wb_b
);

logic [31:0]       regs [`DI_NUM_REGS];
logic [1:0]        wb_valid;
pipe_pkg::result_t wb_q [2];

function automatic logic writes(input pipe_pkg::result_t r);
    return r.valid && !r.have_exception && r.dest != '0;
endfunction

always_comb begin
    for (int i = 0; i < 4; i++) begin
        rf_rdata[i] = (rf_raddr[i] == '0) ? 32'd0 : regs[rf_raddr[i]];
    end
end

// Each result is shown for one cycle. Payload holds through a stall.
always_ff @(posedge clk) begin
    if (rst) begin
        wb_valid <= '0;
    end else if (!stall) begin
        wb_valid <= {ex_b.valid, ex_a.valid};
    end else begin
        wb_valid <= '0;
    end
end

always_ff @(posedge clk) begin
    if (!stall) begin
        wb_q[0] <= ex_a;
        wb_q[1] <= ex_b;
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        for (int i = 0; i < `DI_NUM_REGS; i++) begin
            regs[i] <= 32'd0;   // Architectural state starts at zero.
        end
    end else if (!stall) begin
        if (writes(ex_a)) begin
            regs[ex_a.dest] <= ex_a.value;
        end
        if (writes(ex_b)) begin
            regs[ex_b.dest] <= ex_b.value;  // Younger lane wins.
        end
    end
end

always_comb begin
    wb_a       = wb_q[0];
    wb_a.valid = wb_valid[0];
    wb_b       = wb_q[1];
    wb_b.valid = wb_valid[1];
end

endmodule

//--- src/alu_execute.sv
`timescale 1ns/100ps

module alu_execute (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         stall,
    issue_if.sink                       in_q,
    output pipe_pkg::result_t           res_a,
    output pipe_pkg::result_t           res_b,
    input  wire [31:0]                  rf_rdata [4],
    output logic [pipe_pkg::REG_AW-1:0] rf_raddr [4],
    input  wire pipe_pkg::result_t      wb_a,
    input  wire pipe_pkg::result_t      wb_b
);

pipe_pkg::uop_t    uop [2];
logic [31:0]       opnd [4];
logic [1:0]        ex_valid;
pipe_pkg::result_t ex_q [2];

function automatic logic hit(
    input pipe_pkg::result_t           r,
    input logic [pipe_pkg::REG_AW-1:0] addr
);
    return r.valid && !r.have_exception && r.dest == addr && addr != '0;
endfunction

function automatic pipe_pkg::result_t run(
    input pipe_pkg::uop_t u,
    input logic [31:0]    x,
    input logic [31:0]    y_reg
);
    pipe_pkg::result_t r;
    logic [31:0]       y;
    y                = u.src2_is_imm ? u.imm : y_reg;
    r.valid          = u.valid;
    r.pc             = u.pc;
    r.dest           = u.dest;
    r.have_exception = u.have_exception;
    r.exception_type = u.exception_type;
    case (u.opcode)
        isa_pkg::OP_ADD, isa_pkg::OP_ADDI: r.value = x + y;
        isa_pkg::OP_SUB:                   r.value = x - y;
        isa_pkg::OP_AND:                   r.value = x & y;
        isa_pkg::OP_OR, isa_pkg::OP_ORI:   r.value = x | y;
        isa_pkg::OP_XOR:                   r.value = x ^ y;
        default:                           r.value = 32'd0; // Exception.
    endcase
    return r;
endfunction

assign uop[0]          = in_q.pair.a;
assign uop[1]          = in_q.pair.b;
assign in_q.credit_ret = in_q.push && !stall;

always_comb begin
    for (int i = 0; i < 2; i++) begin
        rf_raddr[2*i]   = uop[i].rf_src1;
        rf_raddr[2*i+1] = uop[i].rf_src2;
    end
end

// Newest first. Lane b is younger than lane a.
always_comb begin
    for (int i = 0; i < 4; i++) begin
        if (hit(res_b, rf_raddr[i])) begin
            opnd[i] = res_b.value;
        end else if (hit(res_a, rf_raddr[i])) begin
            opnd[i] = res_a.value;
        end else if (hit(wb_b, rf_raddr[i])) begin
            opnd[i] = wb_b.value;
        end else if (hit(wb_a, rf_raddr[i])) begin
            opnd[i] = wb_a.value;
        end else begin
            opnd[i] = rf_rdata[i];
        end
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        ex_valid <= '0;
    end else if (!stall) begin
        ex_valid <= {in_q.push && uop[1].valid, in_q.push && uop[0].valid};
    end
end

always_ff @(posedge clk) begin
    if (!stall) begin
        ex_q[0] <= run(uop[0], opnd[0], opnd[1]);
        ex_q[1] <= run(uop[1], opnd[2], opnd[3]);
    end
end

always_comb begin
    res_a       = ex_q[0];
    res_a.valid = ex_valid[0];
    res_b       = ex_q[1];
    res_b.valid = ex_valid[1];
end

endmodule

//--- src/credit_fifo.sv
`timescale 1ns/100ps
`include "dual_issue_cfg.svh"

module credit_fifo #(
    parameter type item_t = pipe_pkg::issue_pair_t
) (
    input  wire     clk,
    input  wire     rst,
    issue_if.sink   in_q,
    issue_if.source out_q,
    input  wire     stall
);

localparam int DEPTH = `DI_QUEUE_DEPTH;
localparam int PTR_W = $clog2(DEPTH);

item_t            mem [DEPTH];
logic [PTR_W-1:0] wr_ptr;
logic [PTR_W-1:0] rd_ptr;
logic [PTR_W:0]   count;
logic             pop;

// Head is offered while execute can advance.
assign out_q.push      = count != '0 && !stall;
assign out_q.pair      = mem[rd_ptr];
assign pop             = out_q.credit_ret && out_q.push;
assign in_q.credit_ret = pop;

always_ff @(posedge clk) begin
    if (rst) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end else begin
        if (in_q.push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
        if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
        case ({in_q.push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (in_q.push) begin
        mem[wr_ptr] <= in_q.pair;
    end
end

endmodule

//--- src/pair_issue.sv
`timescale 1ns/100ps
`include "dual_issue_cfg.svh"

module pair_issue (
    input  wire        clk,
    input  wire        rst,
    input  wire        res_stall,

    input  wire        a_valid,
    input  wire [31:0] a_pc,
    input  wire [31:0] a_inst,
    input  wire        b_valid,
    input  wire [31:0] b_pc,
    input  wire [31:0] b_inst,

    output logic [1:0] consume,
    issue_if.source    iq
);

localparam logic [`DI_CREDIT_W-1:0] FULL_CREDITS = `DI_QUEUE_DEPTH;

pipe_pkg::uop_t          uop_a;
pipe_pkg::uop_t          uop_b;
pipe_pkg::issue_pair_t   pair;
logic                    raw_hazard;
logic                    b_pairs;
logic                    push;
logic [`DI_CREDIT_W-1:0] credits;

inst_decoder decoder_a (
    .valid(a_valid),
    .pc(a_pc),
    .inst(a_inst),
    .uop(uop_a)
);

inst_decoder decoder_b (
    .valid(b_valid),
    .pc(b_pc),
    .inst(b_inst),
    .uop(uop_b)
);

assign raw_hazard = uop_a.dest != '0 &&
                    (uop_a.dest == uop_b.rf_src1 || uop_a.dest == uop_b.rf_src2);
assign b_pairs    = uop_a.valid && uop_b.valid && !uop_a.have_exception && !raw_hazard;

assign consume = (res_stall || credits == '0) ? 2'd0 :
                 b_pairs                      ? 2'd2 :
                 uop_a.valid                  ? 2'd1 :
                                                2'd0;

// A pair costs one credit whether it holds one or two ops.
assign push = consume != 2'd0;

always_comb begin
    pair         = '0;
    pair.a       = uop_a;
    pair.b       = uop_b;
    pair.b.valid = consume == 2'd2;
end

assign iq.push = push;
assign iq.pair = pair;

always_ff @(posedge clk) begin
    if (rst) begin
        credits <= FULL_CREDITS;
    end else begin
        case ({push, iq.credit_ret})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits;
        endcase
    end
end

endmodule

//--- src/inst_decoder.sv
`timescale 1ns/100ps

module inst_decoder (
    input  wire                         valid,
    input  wire [31:0]                  pc,
    input  wire [31:0]                  inst,
    output pipe_pkg::uop_t              uop
);

logic [16:0]                 op3r;
logic [9:0]                  op2ri12;
logic [pipe_pkg::REG_AW-1:0] rd;
logic [pipe_pkg::REG_AW-1:0] rj;
logic [pipe_pkg::REG_AW-1:0] rk;
logic [11:0]                 imm12;
isa_pkg::opcode_t            op;

assign op3r    = inst[31:isa_pkg::OP3R_LSB];
assign op2ri12 = inst[31:isa_pkg::OP2RI12_LSB];
assign rd      = inst[isa_pkg::RD_LSB +: pipe_pkg::REG_AW];
assign rj      = inst[isa_pkg::RJ_LSB +: pipe_pkg::REG_AW];
assign rk      = inst[isa_pkg::RK_LSB +: pipe_pkg::REG_AW];
assign imm12   = inst[isa_pkg::IMM12_LSB +: 12];

always_comb begin
    case (op3r)
        isa_pkg::OP3R_ADD_W: op = isa_pkg::OP_ADD;
        isa_pkg::OP3R_SUB_W: op = isa_pkg::OP_SUB;
        isa_pkg::OP3R_AND:   op = isa_pkg::OP_AND;
        isa_pkg::OP3R_OR:    op = isa_pkg::OP_OR;
        isa_pkg::OP3R_XOR:   op = isa_pkg::OP_XOR;
        default: begin
            case (op2ri12)
                isa_pkg::OP2RI12_ADDI_W: op = isa_pkg::OP_ADDI;
                isa_pkg::OP2RI12_ORI:    op = isa_pkg::OP_ORI;
                default:                 op = isa_pkg::OP_NONE;
            endcase
        end
    endcase
end

always_comb begin
    uop             = '0;
    uop.valid       = valid;
    uop.pc          = pc;
    uop.opcode      = op;
    uop.rf_src1     = rj;
    uop.dest        = rd;
    uop.src2_is_imm = op == isa_pkg::OP_ADDI || op == isa_pkg::OP_ORI;
    uop.rf_src2     = uop.src2_is_imm ? '0 : rk;
    if (op == isa_pkg::OP_ADDI) begin
        uop.imm = {{20{imm12[11]}}, imm12};   // Sign extended.
    end else if (op == isa_pkg::OP_ORI) begin
        uop.imm = {20'd0, imm12};             // Zero extended.
    end
    if (op == isa_pkg::OP_NONE) begin
        uop.have_exception = 1'b1;
        uop.exception_type = isa_pkg::EXC_INE;
        uop.rf_src1        = '0;
        uop.rf_src2        = '0;              // No source operands.
        uop.dest           = '0;              // No register write.
    end
    if (!valid) begin
        uop = '0;
    end
end

endmodule

//--- src/issue_if.sv
`timescale 1ns/100ps

interface issue_if #(
    parameter type item_t = pipe_pkg::issue_pair_t
);

logic  push;       // At most one item per cycle.
item_t pair;
logic  credit_ret; // One pulse per entry freed.

modport source (
    output push,
    output pair,
    input  credit_ret
);

modport sink (
    input  push,
    input  pair,
    output credit_ret
);

endinterface

//--- src/pipe_pkg.sv
`include "dual_issue_cfg.svh"

package pipe_pkg;

localparam int REG_AW = $clog2(`DI_NUM_REGS);

typedef struct packed {
    logic                valid;
    logic [31:0]         pc;
    isa_pkg::opcode_t    opcode;
    logic [REG_AW-1:0]   rf_src1;
    logic [REG_AW-1:0]   rf_src2;      // Zero for immediate forms.
    logic                src2_is_imm;
    logic [31:0]         imm;
    logic [REG_AW-1:0]   dest;
    logic                have_exception;
    isa_pkg::exception_t exception_type;
} uop_t;

// Lane b with valid clear is a single issue.
typedef struct packed {
    uop_t a;
    uop_t b;
} issue_pair_t;

typedef struct packed {
    logic                valid;
    logic [31:0]         pc;
    logic [REG_AW-1:0]   dest;
    logic [31:0]         value;
    logic                have_exception;
    isa_pkg::exception_t exception_type;
} result_t;

endpackage

//--- src/isa_pkg.sv
package isa_pkg;

typedef enum logic [2:0] {
    OP_NONE,
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_ADDI,
    OP_ORI
} opcode_t;

typedef enum logic {
    EXC_NONE,
    EXC_INE                      // Instruction not exist.
} exception_t;

localparam int OP3R_LSB    = 15; // Major opcode is inst[31:15].
localparam int OP2RI12_LSB = 22; // Major opcode is inst[31:22].
localparam int RD_LSB      = 0;
localparam int RJ_LSB      = 5;
localparam int RK_LSB      = 10;
localparam int IMM12_LSB   = 10;

localparam logic [16:0] OP3R_ADD_W     = 17'h00020;
localparam logic [16:0] OP3R_SUB_W     = 17'h00022;
localparam logic [16:0] OP3R_AND       = 17'h00029;
localparam logic [16:0] OP3R_OR        = 17'h0002a;
localparam logic [16:0] OP3R_XOR       = 17'h0002b;
localparam logic [9:0]  OP2RI12_ADDI_W = 10'h00a;
localparam logic [9:0]  OP2RI12_ORI    = 10'h00e;

endpackage

//--- src/dual_issue_cfg.svh
`ifndef DUAL_ISSUE_CFG_SVH
`define DUAL_ISSUE_CFG_SVH

// Architectural integer registers.
`define DI_NUM_REGS    32

// Issue queue entries, one per decoded pair.
`define DI_QUEUE_DEPTH 4

// Holds 0 to DI_QUEUE_DEPTH.
`define DI_CREDIT_W    3

`endif
